// ==== files.f ====
im2col_pkg.sv
im2col_offset_counter.sv
im2col_ctrl_fsm.sv
im2col_trans_fifo.sv
im2col_dma_loader.sv
im2col_channel_tracker.sv
im2col_spc.sv
tb_im2col_spc_sva.sv
tb_im2col_spc.sv

// ==== run.sh ====
#!/bin/sh
# Build the im2col testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert -f files.f --top-module tb_im2col_spc -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -qx "No errors" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== tb_im2col_spc.sv ====
// Testbench for the im2col engine with a DMA model, a reference write list and a checker
`default_nettype none

module tb_im2col_spc;
  import im2col_pkg::*;

  logic              clk_i;
  logic              rst_ni;
  logic              start_i;
  im2col_cfg_t       cfg_i;
  dma_wr_t           dma_wr_o;
  logic              dma_ready_i;
  logic [CH_NUM-1:0] dma_done_i;
  logic              busy_o;
  logic              done_o;
  logic              irq_o;
  logic              irq_clear_i;

  logic        rand_ready;  // DMA model toggles ready randomly
  string       test_name;
  logic [31:0] exp_off[$];
  logic [31:0] exp_data[$];
  int          kick[CH_NUM];  // SIZE_D1 writes seen per channel
  int          err_main;
  int          err_mon;
  int          tests_run;
  logic        timed_out;

  // Monitor state of the running job
  logic        active;
  int          wr_idx;
  int          done_cnt;
  int          dim_cnt;
  logic        dim_seen[CH_NUM];
  logic        used[CH_NUM];
  logic        outstanding[CH_NUM];  // Channel started with its done pulse pending

  im2col_spc UUT (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (start_i),
    .cfg_i       (cfg_i),
    .dma_wr_o    (dma_wr_o),
    .dma_ready_i (dma_ready_i),
    .dma_done_i  (dma_done_i),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .irq_o       (irq_o),
    .irq_clear_i (irq_clear_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic im2col_cfg_t make_cfg(input int iw, ih, fw, fh, nch, s1, s2, pt, pl,
                                           input logic [CH_NUM-1:0] mask, input logic irq);
    im2col_cfg_t c;
    c.src_ptr     = 32'h1000_0000;
    c.dst_ptr     = 32'h2000_0000;
    c.iw          = 16'(iw);
    c.ih          = 16'(ih);
    c.n_patches_w = 16'((iw + pl - fw) / s1 + 1);  // Last patch ends inside the right edge
    c.n_patches_h = 16'((ih + pt - fh) / s2 + 1);
    c.fw          = 8'(fw);
    c.fh          = 8'(fh);
    c.num_ch      = 8'(nch);
    c.stride_d1   = 8'(s1);
    c.stride_d2   = 8'(s2);
    c.pad_top     = 6'(pt);
    c.pad_left    = 6'(pl);
    c.ch_mask     = mask;
    c.irq_en      = irq;
    return c;
  endfunction

  function automatic void add_write(input logic [31:0] off, input logic [31:0] data);
    exp_off.push_back(off);
    exp_data.push_back(data);
  endfunction

  // Expected writes in loader order without the dimensionality writes
  function automatic void build_expected(input im2col_cfg_t c);
    int pl;
    int pt;
    int s1;
    int s2;
    int iw;
    int npw;
    int nph;
    int nzl;
    int nzt;
    int sz1;
    int sz2;
    int idx;
    int k;
    exp_off.delete();
    exp_data.delete();
    pl  = int'(c.pad_left);
    pt  = int'(c.pad_top);
    s1  = int'(c.stride_d1);
    s2  = int'(c.stride_d2);
    iw  = int'(c.iw);
    npw = int'(c.n_patches_w);
    nph = int'(c.n_patches_h);
    k   = 0;
    for (int ic = 0; ic < int'(c.num_ch); ic++) begin
      for (int h = 0; h < int'(c.fh); h++) begin
        for (int w = 0; w < int'(c.fw); w++) begin
          nzl = (w >= pl) ? 0 : (pl - w + s1 - 1) / s1;  // Ceiling of gap over stride
          nzt = (h >= pt) ? 0 : (pt - h + s2 - 1) / s2;
          sz1 = npw - nzl;
          sz2 = nph - nzt;
          idx = (ic * int'(c.ih) + h - pt + nzt * s2) * iw + w - pl + nzl * s1;
          add_write(DMA_TOP_PAD_OFFSET, 32'(nzt * 4) & PAD_MASK);
          add_write(DMA_LEFT_PAD_OFFSET, 32'(nzl * 4) & PAD_MASK);
          add_write(DMA_SRC_PTR_OFFSET, c.src_ptr + 32'(idx * 4));
          add_write(DMA_DST_PTR_OFFSET, c.dst_ptr + 32'(k * npw * nph * 4));
          add_write(DMA_INC_SRC_D1_OFFSET, 32'(s1 * 4) & INC_D1_MASK);
          add_write(DMA_INC_SRC_D2_OFFSET, 32'((s2 * iw - (sz1 - 1) * s1) * 4) & INC_D2_MASK);
          add_write(DMA_INC_DST_D1_OFFSET, 32'd4);
          add_write(DMA_INC_DST_D2_OFFSET, 32'd4);
          add_write(DMA_SIZE_D2_OFFSET, 32'(sz2 * 4) & SIZE_MASK);
          add_write(DMA_SIZE_D1_OFFSET, 32'(sz1 * 4) & SIZE_MASK);
          k++;
        end
      end
    end
  endfunction

  // DMA model driving ready and the per-channel done pulses
  initial begin
    logic [31:0] rng;
    int          cnt[CH_NUM];
    int          seen[CH_NUM];
    rng         = 32'd52;
    dma_ready_i = 1'b0;
    dma_done_i  = '0;
    for (int ch = 0; ch < CH_NUM; ch++) begin
      cnt[ch]  = 0;
      seen[ch] = 0;
    end
    forever begin
      @(negedge clk_i);
      rng         = lcg_next(rng);
      dma_ready_i = rand_ready ? (rng[31:30] != 2'b00) : 1'b1;
      for (int ch = 0; ch < CH_NUM; ch++) begin
        dma_done_i[ch] = 1'b0;
        if (cnt[ch] > 0) begin
          cnt[ch]--;
          if (cnt[ch] == 0) dma_done_i[ch] = 1'b1;
        end
        if (kick[ch] != seen[ch]) begin
          seen[ch] = kick[ch];
          rng      = lcg_next(rng);
          cnt[ch]  = 3 + int'(rng[23:16] % 8'd18);  // 3 to 20 cycles
        end
      end
    end
  end

  // Monitor comparing every completed write with the reference list
  initial begin
    logic [31:0] rel;
    logic [31:0] off;
    int          ch;
    active   = 1'b0;
    wr_idx   = 0;
    done_cnt = 0;
    dim_cnt  = 0;
    err_mon  = 0;
    for (int c = 0; c < CH_NUM; c++) begin
      kick[c]        = 0;
      dim_seen[c]    = 1'b0;
      used[c]        = 1'b0;
      outstanding[c] = 1'b0;
    end
    forever begin
      @(posedge clk_i);
      if (rst_ni) begin
        for (int c = 0; c < CH_NUM; c++) begin
          if (dma_done_i[c]) outstanding[c] = 1'b0;
        end
        if (dma_wr_o.valid && dma_ready_i) begin
          rel = dma_wr_o.addr - DMA_BASE_ADDR;
          ch  = int'(rel / DMA_CH_SIZE);
          off = rel % DMA_CH_SIZE;
          if (ch >= CH_NUM || !cfg_i.ch_mask[ch]) begin
            $display("test %s: write to disabled channel at 0x%h", test_name, dma_wr_o.addr);
            err_mon++;
          end else if (off == DMA_DIMENSIONALITY_OFFSET) begin
            if (dim_seen[ch] || used[ch]) begin
              $display("test %s: extra dimensionality write on channel %0d", test_name, ch);
              err_mon++;
            end
            if (dma_wr_o.wdata != 32'd1) begin
              $display("error %s: dimensionality expected %h actual %h",
                       test_name, 32'd1, dma_wr_o.wdata);
              err_mon++;
            end
            dim_seen[ch] = 1'b1;
            dim_cnt++;
          end else begin
            if (!dim_seen[ch]) begin
              $display("test %s: channel %0d written before its dimensionality", test_name, ch);
              err_mon++;
            end
            used[ch] = 1'b1;
            if (wr_idx >= exp_off.size()) begin
              $display("test %s: more writes than expected", test_name);
              err_mon++;
            end else begin
              if (off != exp_off[wr_idx]) begin
                $display("error %s: write %0d offset expected %h actual %h",
                         test_name, wr_idx, exp_off[wr_idx], off);
                err_mon++;
              end
              if (dma_wr_o.wdata != exp_data[wr_idx]) begin
                $display("error %s: write %0d data expected %h actual %h",
                         test_name, wr_idx, exp_data[wr_idx], dma_wr_o.wdata);
                err_mon++;
              end
            end
            wr_idx++;
            if (off == DMA_SIZE_D1_OFFSET) begin
              outstanding[ch] = 1'b1;
              kick[ch]++;  // Channel runs now
            end
          end
        end
        if (active) begin
          if (!busy_o) begin
            $display("test %s: busy_o low during the job", test_name);
            err_mon++;
          end
          if (done_o) begin
            done_cnt++;
            active = 1'b0;
            for (int c = 0; c < CH_NUM; c++) begin
              if (outstanding[c]) begin
                $display("test %s: done_o before channel %0d finished", test_name, c);
                err_mon++;
              end
            end
          end
        end else if (done_o) begin
          $display("test %s: done_o pulsed outside a job", test_name);
          err_mon++;
        end
        if (active && !cfg_i.irq_en && irq_o) begin
          $display("test %s: irq_o high with interrupts disabled", test_name);
          err_mon++;
        end
        if (start_i && !busy_o) begin
          active   = 1'b1;
          wr_idx   = 0;
          done_cnt = 0;
          dim_cnt  = 0;
          for (int c = 0; c < CH_NUM; c++) begin
            dim_seen[c] = 1'b0;
            used[c]     = 1'b0;
          end
        end
      end
    end
  end

  task automatic run_job(input im2col_cfg_t c, input logic rnd);
    int t;
    if (timed_out) begin
      $display("test %s: not run after an earlier timeout", test_name);
      err_main++;
      return;
    end
    cfg_i      = c;
    rand_ready = rnd;
    build_expected(c);
    start_i = 1'b1;
    @(negedge clk_i);
    start_i = 1'b0;
    t = 0;
    while (!done_o && t < 20000) begin
      @(negedge clk_i);
      t++;
    end
    if (!done_o) begin
      $display("test %s: timed out waiting for done_o", test_name);
      err_main++;
      timed_out = 1'b1;
      return;
    end
    repeat (5) @(negedge clk_i);  // Room for a stray second done pulse
    if (done_cnt != 1) begin
      $display("error %s: done pulses expected 1 actual %0d", test_name, done_cnt);
      err_main++;
    end
    if (wr_idx != exp_off.size()) begin
      $display("error %s: writes expected %0d actual %0d", test_name, exp_off.size(), wr_idx);
      err_main++;
    end
    for (int ch = 0; ch < CH_NUM; ch++) begin
      if (dim_seen[ch] != used[ch]) begin
        $display("error %s: channel %0d dimensionality writes expected %0d actual %0d",
                 test_name, ch, used[ch], dim_seen[ch]);
        err_main++;
      end
    end
  endtask

  function automatic void report_test(input int base);
    int n;
    n = err_main + err_mon - base;
    tests_run++;
    if (n == 0) $display("test %s: passed", test_name);
    else $display("test %s: failed with %0d errors", test_name, n);
  endfunction

  initial begin
    int base;
    rst_ni      = 1'b0;
    start_i     = 1'b0;
    irq_clear_i = 1'b0;
    cfg_i       = '0;
    rand_ready  = 1'b0;
    err_main    = 0;
    tests_run   = 0;
    timed_out   = 1'b0;
    test_name   = "reset";
    repeat (8) @(negedge clk_i);
    base   = err_main + err_mon;
    rst_ni = 1'b1;
    @(negedge clk_i);
    if (dma_wr_o.valid || busy_o || done_o || irq_o) begin
      $display("error %s: valid busy done irq expected 0000 actual %b%b%b%b",
               test_name, dma_wr_o.valid, busy_o, done_o, irq_o);
      err_main++;
    end
    report_test(base);

    test_name = "stride1_one_channel";
    base      = err_main + err_mon;
    run_job(make_cfg(8, 6, 2, 2, 1, 1, 1, 0, 0, 4'b0001, 1'b0), 1'b0);
    if (!timed_out && dim_cnt != 1) begin
      $display("error %s: dimensionality writes expected 1 actual %0d", test_name, dim_cnt);
      err_main++;
    end
    report_test(base);

    test_name = "stride2_padding_irq";
    base      = err_main + err_mon;
    run_job(make_cfg(9, 9, 3, 3, 2, 2, 2, 1, 3, 4'b0011, 1'b1), 1'b0);
    if (!timed_out) begin
      if (irq_o != 1'b1) begin
        $display("error %s: irq_o after done expected 1 actual %0d", test_name, irq_o);
        err_main++;
      end
      irq_clear_i = 1'b1;
      @(negedge clk_i);
      irq_clear_i = 1'b0;
      @(negedge clk_i);
      if (irq_o != 1'b0) begin
        $display("error %s: irq_o after clear expected 0 actual %0d", test_name, irq_o);
        err_main++;
      end
    end
    report_test(base);

    test_name = "four_channels_random";
    base      = err_main + err_mon;
    run_job(make_cfg(10, 7, 3, 2, 3, 1, 2, 1, 1, 4'b1111, 1'b0), 1'b1);
    if (!timed_out && irq_o != 1'b0) begin
      $display("error %s: irq_o expected 0 actual %0d", test_name, irq_o);
      err_main++;
    end
    report_test(base);

    test_name = "two_channel_mask";
    base      = err_main + err_mon;
    run_job(make_cfg(8, 8, 2, 3, 2, 1, 1, 2, 0, 4'b0101, 1'b0), 1'b1);
    report_test(base);

    $display("tests %0d, errors %0d", tests_run, err_main + err_mon);
    if (err_main + err_mon == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_im2col_spc_sva.sv ====
// Write bus handshake and job completion assertions bound to the im2col top level
`default_nettype none

module tb_im2col_spc_sva (
  input logic                clk_i,
  input logic                rst_ni,
  input im2col_pkg::dma_wr_t dma_wr_o,
  input logic                dma_ready_i,
  input logic                busy_o,
  input logic                done_o
);

  // Request held until the DMA takes it
  a_wr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dma_wr_o.valid && !dma_ready_i |=>
      dma_wr_o.valid && $stable(dma_wr_o.addr) && $stable(dma_wr_o.wdata))
    else $error("write request changed before ready");

  a_wr_gap: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dma_wr_o.valid && dma_ready_i |=> !dma_wr_o.valid)
    else $error("valid did not drop after a completed write");

  a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |=> !done_o)
    else $error("done_o longer than one cycle");

  a_busy_after_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |=> !busy_o)
    else $error("busy_o still high after done_o");

endmodule

bind im2col_spc tb_im2col_spc_sva u_sva (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .dma_wr_o    (dma_wr_o),
  .dma_ready_i (dma_ready_i),
  .busy_o      (busy_o),
  .done_o      (done_o)
);

`default_nettype wire

// ==== im2col_spc.sv ====
// im2col transaction engine top level joining FSM, counter, FIFO, loader and tracker
`default_nettype none

module im2col_spc (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          start_i,
  input  im2col_pkg::im2col_cfg_t       cfg_i,
  output im2col_pkg::dma_wr_t           dma_wr_o,
  input  logic                          dma_ready_i,
  input  logic [im2col_pkg::CH_NUM-1:0] dma_done_i,
  output logic                          busy_o,
  output logic                          done_o,
  output logic                          irq_o,
  input  logic                          irq_clear_i
);
  import im2col_pkg::*;

  logic [15:0] w_offset;
  logic [15:0] h_offset;
  logic [15:0] im_c;
  logic        last;
  logic        step;
  logic        clear;
  logic        push;
  logic        pop;
  logic        fifo_full;
  logic        fifo_empty;
  dma_trans_t  trans_in;
  dma_trans_t  trans_head;
  logic        claim;
  logic        loader_idle;
  logic        all_idle;
  logic        job_end;
  ch_idx_t     free_ch;
  logic        any_free;
  logic        first_use;

  im2col_offset_counter u_counter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clear_i    (clear),
    .step_i     (step),
    .cfg_i      (cfg_i),
    .w_offset_o (w_offset),
    .h_offset_o (h_offset),
    .im_c_o     (im_c),
    .last_o     (last)
  );

  im2col_ctrl_fsm u_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (start_i),
    .cfg_i         (cfg_i),
    .w_offset_i    (w_offset),
    .h_offset_i    (h_offset),
    .im_c_i        (im_c),
    .last_i        (last),
    .fifo_full_i   (fifo_full),
    .fifo_empty_i  (fifo_empty),
    .loader_idle_i (loader_idle),
    .all_idle_i    (all_idle),
    .irq_clear_i   (irq_clear_i),
    .step_o        (step),
    .clear_o       (clear),
    .push_o        (push),
    .trans_o       (trans_in),
    .busy_o        (busy_o),
    .done_o        (done_o),
    .job_end_o     (job_end),
    .irq_o         (irq_o)
  );

  im2col_trans_fifo u_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (push),
    .data_i  (trans_in),
    .pop_i   (pop),
    .data_o  (trans_head),
    .full_o  (fifo_full),
    .empty_o (fifo_empty)
  );

  im2col_dma_loader u_loader (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cfg_i        (cfg_i),
    .trans_i      (trans_head),
    .fifo_empty_i (fifo_empty),
    .any_free_i   (any_free),
    .free_ch_i    (free_ch),
    .first_use_i  (first_use),
    .dma_ready_i  (dma_ready_i),
    .pop_o        (pop),
    .claim_o      (claim),
    .idle_o       (loader_idle),
    .dma_wr_o     (dma_wr_o)
  );

  im2col_channel_tracker u_tracker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ch_mask_i   (cfg_i.ch_mask),
    .claim_i     (claim),
    .dma_done_i  (dma_done_i),
    .job_end_i   (job_end),
    .free_ch_o   (free_ch),
    .any_free_o  (any_free),
    .first_use_o (first_use),
    .all_idle_o  (all_idle)
  );

endmodule

`default_nettype wire

// ==== im2col_channel_tracker.sv ====
// DMA channel busy and first-use bookkeeping with lowest free channel search
`default_nettype none

module im2col_channel_tracker (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic [im2col_pkg::CH_NUM-1:0] ch_mask_i,
  input  logic                          claim_i,
  input  logic [im2col_pkg::CH_NUM-1:0] dma_done_i,
  input  logic                          job_end_i,
  output im2col_pkg::ch_idx_t           free_ch_o,
  output logic                          any_free_o,
  output logic                          first_use_o,
  output logic                          all_idle_o
);
  import im2col_pkg::*;

  logic [CH_NUM-1:0] busy_q;
  logic [CH_NUM-1:0] written_q;  // Dimensionality already programmed
  logic [CH_NUM-1:0] avail;

  assign avail = ch_mask_i & ~busy_q;

  always_comb begin
    free_ch_o = '0;
    for (int i = CH_NUM - 1; i >= 0; i--) begin
      if (avail[i]) free_ch_o = ch_idx_t'(i);  // Lowest index wins
    end
  end

  assign any_free_o  = |avail;
  assign first_use_o = !written_q[free_ch_o];
  assign all_idle_o  = !(|busy_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q    <= '0;
      written_q <= '0;
    end else begin
      busy_q <= busy_q & ~dma_done_i;
      if (job_end_i) written_q <= '0;
      if (claim_i) begin
        busy_q[free_ch_o]    <= 1'b1;
        written_q[free_ch_o] <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== im2col_dma_loader.sv ====
// Sequencer programming one FIFO transaction into a claimed DMA channel
`default_nettype none

module im2col_dma_loader (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  im2col_pkg::im2col_cfg_t cfg_i,
  input  im2col_pkg::dma_trans_t  trans_i,
  input  logic                    fifo_empty_i,
  input  logic                    any_free_i,
  input  im2col_pkg::ch_idx_t     free_ch_i,
  input  logic                    first_use_i,
  input  logic                    dma_ready_i,
  output logic                    pop_o,
  output logic                    claim_o,
  output logic                    idle_o,
  output im2col_pkg::dma_wr_t     dma_wr_o
);
  import im2col_pkg::*;

  dma_reg_e    state_q;
  dma_reg_e    state_d;
  ch_idx_t     ch_q;
  logic        valid_q;
  logic        wr_done;
  logic [31:0] reg_off;
  logic [31:0] reg_data;

  assign claim_o = (state_q == REG_IDLE) && !fifo_empty_i && any_free_i;
  assign wr_done = valid_q && dma_ready_i;
  assign pop_o   = (state_q == REG_POP);
  assign idle_o  = (state_q == REG_IDLE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      REG_IDLE: begin
        if (claim_o) begin
          state_d = first_use_i ? REG_DIMENSIONALITY : REG_TOP_PAD;
        end
      end
      REG_POP: state_d = REG_IDLE;
      default: if (wr_done) state_d = dma_reg_e'(state_q + 4'd1);  // Next opcode
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= REG_IDLE;
      ch_q    <= '0;
      valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (claim_o) ch_q <= free_ch_i;
      if (wr_done) begin
        valid_q <= 1'b0;  // At least one low cycle between writes
      end else if (state_q != REG_IDLE && state_q != REG_POP) begin
        valid_q <= 1'b1;
      end
    end
  end

  always_comb begin
    reg_off  = '0;
    reg_data = '0;
    case (state_q)
      REG_DIMENSIONALITY: begin
        reg_off  = DMA_DIMENSIONALITY_OFFSET;
        reg_data = 32'd1;  // 2-D transfers
      end
      REG_TOP_PAD: begin
        reg_off  = DMA_TOP_PAD_OFFSET;
        reg_data = (trans_i.n_zeros_top * WORD_BYTES) & PAD_MASK;
      end
      REG_LEFT_PAD: begin
        reg_off  = DMA_LEFT_PAD_OFFSET;
        reg_data = (trans_i.n_zeros_left * WORD_BYTES) & PAD_MASK;
      end
      REG_SRC_PTR: begin
        reg_off  = DMA_SRC_PTR_OFFSET;
        reg_data = trans_i.input_ptr;
      end
      REG_DST_PTR: begin
        reg_off  = DMA_DST_PTR_OFFSET;
        reg_data = trans_i.output_ptr;
      end
      REG_INC_SRC_D1: begin
        reg_off  = DMA_INC_SRC_D1_OFFSET;
        reg_data = (32'(cfg_i.stride_d1) * WORD_BYTES) & INC_D1_MASK;
      end
      REG_INC_SRC_D2: begin
        reg_off  = DMA_INC_SRC_D2_OFFSET;
        reg_data = (trans_i.in_inc_d2 * WORD_BYTES) & INC_D2_MASK;
      end
      REG_INC_DST_D1: begin
        reg_off  = DMA_INC_DST_D1_OFFSET;
        reg_data = WORD_BYTES;  // Output is contiguous
      end
      REG_INC_DST_D2: begin
        reg_off  = DMA_INC_DST_D2_OFFSET;
        reg_data = WORD_BYTES;
      end
      REG_SIZE_D2: begin
        reg_off  = DMA_SIZE_D2_OFFSET;
        reg_data = (trans_i.size_d2 * WORD_BYTES) & SIZE_MASK;
      end
      REG_SIZE_D1: begin
        reg_off  = DMA_SIZE_D1_OFFSET;  // Last write, starts the channel
        reg_data = (trans_i.size_d1 * WORD_BYTES) & SIZE_MASK;
      end
      default: ;
    endcase
  end

  assign dma_wr_o.valid = valid_q;
  assign dma_wr_o.addr  = DMA_BASE_ADDR + 32'(ch_q) * DMA_CH_SIZE + reg_off;
  assign dma_wr_o.wdata = reg_data;

endmodule

`default_nettype wire

// ==== im2col_trans_fifo.sv ====
// Fall-through circular FIFO holding pending DMA transactions
`default_nettype none

module im2col_trans_fifo (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   push_i,
  input  im2col_pkg::dma_trans_t data_i,
  input  logic                   pop_i,
  output im2col_pkg::dma_trans_t data_o,
  output logic                   full_o,
  output logic                   empty_o
);
  import im2col_pkg::*;

  dma_trans_t            mem_q [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr_q;
  logic [FIFO_PTR_W-1:0] rd_ptr_q;
  logic [FIFO_PTR_W:0]   count_q;
  logic                  do_push;
  logic                  do_pop;

  assign full_o  = (count_q == (FIFO_PTR_W + 1)'(FIFO_DEPTH));
  assign empty_o = (count_q == '0);
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;
  assign data_o  = mem_q[rd_ptr_q];  // Head visible without a pop

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + FIFO_PTR_W'(1);  // Wraps after the last slot
      if (do_pop) rd_ptr_q <= rd_ptr_q + FIFO_PTR_W'(1);
      count_q <= count_q + (FIFO_PTR_W + 1)'(do_push) - (FIFO_PTR_W + 1)'(do_pop);
    end
  end

endmodule

`default_nettype wire

// ==== im2col_ctrl_fsm.sv ====
// Job FSM computing one strided DMA transaction per filter offset and signalling completion
`default_nettype none

module im2col_ctrl_fsm (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    start_i,
  input  im2col_pkg::im2col_cfg_t cfg_i,
  input  logic [15:0]             w_offset_i,
  input  logic [15:0]             h_offset_i,
  input  logic [15:0]             im_c_i,
  input  logic                    last_i,
  input  logic                    fifo_full_i,
  input  logic                    fifo_empty_i,
  input  logic                    loader_idle_i,
  input  logic                    all_idle_i,
  input  logic                    irq_clear_i,
  output logic                    step_o,
  output logic                    clear_o,
  output logic                    push_o,
  output im2col_pkg::dma_trans_t  trans_o,
  output logic                    busy_o,
  output logic                    done_o,
  output logic                    job_end_o,
  output logic                    irq_o
);
  import im2col_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        irq_q;

  logic        left_in_q;  // Offset already inside the image
  logic        top_in_q;
  logic [31:0] left_gap_q;
  logic [31:0] top_gap_q;
  logic [31:0] ch_base_q;
  logic [31:0] im_row_q;
  logic [31:0] im_col_q;
  logic [31:0] nz_left_q;
  logic [31:0] nz_top_q;
  logic [31:0] size_d1_q;
  logic [31:0] size_d2_q;
  logic [31:0] index_q;
  logic [31:0] in_inc_d2_q;
  logic [31:0] input_ptr_q;
  logic [31:0] out_ptr_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      CTRL_IDLE:         if (start_i) state_d = CTRL_F_MIN_OFFSET;
      CTRL_F_MIN_OFFSET: state_d = CTRL_IM_COORD;
      CTRL_IM_COORD:     state_d = CTRL_N_ZEROS;
      CTRL_N_ZEROS:      state_d = CTRL_PARAM_1;
      CTRL_PARAM_1:      state_d = CTRL_PARAM_2;
      CTRL_PARAM_2:      if (!fifo_full_i) state_d = CTRL_PUSH;  // Back-pressure
      CTRL_PUSH:         state_d = last_i ? CTRL_DRAIN : CTRL_OFFSET_STEP;
      CTRL_OFFSET_STEP:  state_d = CTRL_F_MIN_OFFSET;
      CTRL_DRAIN: begin
        if (fifo_empty_i && loader_idle_i && all_idle_i) begin
          state_d = CTRL_DONE;
        end
      end
      CTRL_DONE:         state_d = CTRL_IDLE;
      default:           state_d = CTRL_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= CTRL_IDLE;
      irq_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (done_o && cfg_i.irq_en) begin
        irq_q <= 1'b1;
      end else if (irq_clear_i) begin
        irq_q <= 1'b0;
      end
    end
  end

  // Transaction datapath, one stage per state
  always_ff @(posedge clk_i) begin
    case (state_q)
      CTRL_IDLE: out_ptr_q <= cfg_i.dst_ptr;
      CTRL_F_MIN_OFFSET: begin
        left_in_q  <= w_offset_i >= 16'(cfg_i.pad_left);
        top_in_q   <= h_offset_i >= 16'(cfg_i.pad_top);
        left_gap_q <= 32'(cfg_i.pad_left) - 32'(w_offset_i);
        top_gap_q  <= 32'(cfg_i.pad_top) - 32'(h_offset_i);
        ch_base_q  <= 32'(im_c_i) * 32'(cfg_i.ih);  // Batch fixed at 1
      end
      CTRL_IM_COORD: begin
        im_row_q <= 32'(h_offset_i) - 32'(cfg_i.pad_top);
        im_col_q <= 32'(w_offset_i) - 32'(cfg_i.pad_left);
      end
      CTRL_N_ZEROS: begin
        // Ceiling division of the padding gap by the stride
        nz_left_q <= left_in_q ? '0 :
                     (left_gap_q + 32'(cfg_i.stride_d1) - 32'd1) / 32'(cfg_i.stride_d1);
        nz_top_q  <= top_in_q ? '0 :
                     (top_gap_q + 32'(cfg_i.stride_d2) - 32'd1) / 32'(cfg_i.stride_d2);
      end
      CTRL_PARAM_1: begin
        size_d1_q <= 32'(cfg_i.n_patches_w) - nz_left_q;
        size_d2_q <= 32'(cfg_i.n_patches_h) - nz_top_q;
        index_q   <= (ch_base_q + im_row_q + nz_top_q * 32'(cfg_i.stride_d2)) * 32'(cfg_i.iw)
                     + im_col_q + nz_left_q * 32'(cfg_i.stride_d1);
      end
      CTRL_PARAM_2: begin
        in_inc_d2_q <= 32'(cfg_i.stride_d2) * 32'(cfg_i.iw)
                       - (size_d1_q - 32'd1) * 32'(cfg_i.stride_d1);
        input_ptr_q <= cfg_i.src_ptr + index_q * WORD_BYTES;
      end
      CTRL_PUSH: begin
        out_ptr_q <= out_ptr_q
                     + 32'(cfg_i.n_patches_h) * 32'(cfg_i.n_patches_w) * WORD_BYTES;
      end
      default: ;
    endcase
  end

  always_comb begin
    trans_o.input_ptr    = input_ptr_q;
    trans_o.output_ptr   = out_ptr_q;
    trans_o.in_inc_d2    = in_inc_d2_q;
    trans_o.n_zeros_top  = nz_top_q;
    trans_o.n_zeros_left = nz_left_q;
    trans_o.size_d1      = size_d1_q;
    trans_o.size_d2      = size_d2_q;
  end

  assign clear_o   = (state_q == CTRL_IDLE) && start_i;
  assign step_o    = (state_q == CTRL_OFFSET_STEP);
  assign push_o    = (state_q == CTRL_PUSH);
  assign busy_o    = (state_q != CTRL_IDLE);
  assign done_o    = (state_q == CTRL_DONE);
  assign job_end_o = (state_q == CTRL_DONE);  // Clears first-use flags
  assign irq_o     = irq_q;

endmodule

`default_nettype wire

// ==== im2col_offset_counter.sv ====
// Filter window walker stepping w offset, then h offset, then input channel
`default_nettype none

module im2col_offset_counter (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    step_i,
  input  im2col_pkg::im2col_cfg_t cfg_i,
  output logic [15:0]             w_offset_o,
  output logic [15:0]             h_offset_o,
  output logic [15:0]             im_c_o,
  output logic                    last_o
);

  logic w_wrap;
  logic h_wrap;

  assign w_wrap = (w_offset_o == 16'(cfg_i.fw) - 16'd1);
  assign h_wrap = (h_offset_o == 16'(cfg_i.fh) - 16'd1);
  assign last_o = w_wrap && h_wrap && (im_c_o == 16'(cfg_i.num_ch) - 16'd1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_offset_o <= '0;
      h_offset_o <= '0;
      im_c_o     <= '0;
    end else if (clear_i) begin
      w_offset_o <= '0;
      h_offset_o <= '0;
      im_c_o     <= '0;
    end else if (step_i) begin
      w_offset_o <= w_wrap ? '0 : w_offset_o + 16'd1;  // Fastest index
      if (w_wrap) begin
        h_offset_o <= h_wrap ? '0 : h_offset_o + 16'd1;
        if (h_wrap) begin
          im_c_o <= im_c_o + 16'd1;  // Next input channel
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== im2col_pkg.sv ====
// im2col engine shared constants, DMA register map, transaction and config types
`default_nettype none

package im2col_pkg;

  localparam int unsigned CH_NUM     = 4;
  localparam int unsigned CH_IDX_W   = 2;
  localparam int unsigned FIFO_DEPTH = 4;
  localparam int unsigned FIFO_PTR_W = $clog2(FIFO_DEPTH);

  localparam logic [31:0] WORD_BYTES    = 32'd4;  // 32-bit elements only
  localparam logic [31:0] DMA_BASE_ADDR = 32'h0003_0000;
  localparam logic [31:0] DMA_CH_SIZE   = 32'h0000_0100;

  // Per-channel register offsets
  localparam logic [31:0] DMA_SRC_PTR_OFFSET        = 32'h00;
  localparam logic [31:0] DMA_DST_PTR_OFFSET        = 32'h04;
  localparam logic [31:0] DMA_SIZE_D1_OFFSET        = 32'h0C;
  localparam logic [31:0] DMA_SIZE_D2_OFFSET        = 32'h10;
  localparam logic [31:0] DMA_INC_SRC_D1_OFFSET     = 32'h18;
  localparam logic [31:0] DMA_INC_SRC_D2_OFFSET     = 32'h1C;
  localparam logic [31:0] DMA_INC_DST_D1_OFFSET     = 32'h20;
  localparam logic [31:0] DMA_INC_DST_D2_OFFSET     = 32'h24;
  localparam logic [31:0] DMA_DIMENSIONALITY_OFFSET = 32'h34;
  localparam logic [31:0] DMA_TOP_PAD_OFFSET        = 32'h3C;
  localparam logic [31:0] DMA_LEFT_PAD_OFFSET       = 32'h48;

  // Register field widths
  localparam logic [31:0] PAD_MASK    = 32'h0000_003F;
  localparam logic [31:0] INC_D1_MASK = 32'h0000_003F;
  localparam logic [31:0] INC_D2_MASK = 32'h007F_FFFF;
  localparam logic [31:0] SIZE_MASK   = 32'h0000_FFFF;

  typedef logic [CH_IDX_W-1:0] ch_idx_t;

  typedef struct packed {
    logic [31:0]       src_ptr;
    logic [31:0]       dst_ptr;
    logic [15:0]       iw;
    logic [15:0]       ih;
    logic [15:0]       n_patches_w;
    logic [15:0]       n_patches_h;
    logic [7:0]        fw;
    logic [7:0]        fh;
    logic [7:0]        num_ch;
    logic [7:0]        stride_d1;
    logic [7:0]        stride_d2;
    logic [5:0]        pad_top;
    logic [5:0]        pad_left;
    logic [CH_NUM-1:0] ch_mask;
    logic              irq_en;
  } im2col_cfg_t;

  typedef struct packed {
    logic [31:0] input_ptr;
    logic [31:0] output_ptr;
    logic [31:0] in_inc_d2;
    logic [31:0] n_zeros_top;
    logic [31:0] n_zeros_left;
    logic [31:0] size_d1;
    logic [31:0] size_d2;
  } dma_trans_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [31:0] wdata;
  } dma_wr_t;

  typedef enum logic [3:0] {
    CTRL_IDLE,
    CTRL_F_MIN_OFFSET,
    CTRL_IM_COORD,
    CTRL_N_ZEROS,
    CTRL_PARAM_1,
    CTRL_PARAM_2,
    CTRL_PUSH,
    CTRL_OFFSET_STEP,
    CTRL_DRAIN,
    CTRL_DONE
  } ctrl_state_e;

  // Listed in the order the loader writes them
  typedef enum logic [3:0] {
    REG_IDLE,
    REG_DIMENSIONALITY,
    REG_TOP_PAD,
    REG_LEFT_PAD,
    REG_SRC_PTR,
    REG_DST_PTR,
    REG_INC_SRC_D1,
    REG_INC_SRC_D2,
    REG_INC_DST_D1,
    REG_INC_DST_D2,
    REG_SIZE_D2,
    REG_SIZE_D1,
    REG_POP
  } dma_reg_e;

endpackage

`default_nettype wire
